/* source/routerPort_params.svh */
`ifndef ROUTER_PORT_PARAMS_SVH
`define ROUTER_PORT_PARAMS_SVH

// Input ports feeding one output port (L, N, E, W, S).
`define NUM_PORTS 5

// Flit kind field.
`define FLIT_ID_W 3

// Header length field, the hold limit in cycles.
`define LENGTH_W 12

// Flit payload.
`define DATA_W 16

`endif

/* source/nocFlitPkg.sv */
`include "routerPort_params.svh"

package nocFlitPkg;

  // Flit kinds as carried in the kind field, one bit each.
  typedef enum logic [`FLIT_ID_W-1:0] {
    HEADER = 3'd1,
    BODY   = 3'd2,
    TAIL   = 3'd4
  } flitKind;

  // Input port index, also used as the source tag on the output.
  typedef enum logic [2:0] {
    LOCAL = 3'd0,
    NORTH,
    EAST,
    WEST,
    SOUTH
  } portIdx;

endpackage

/* source/nocArbPkg.sv */
`include "routerPort_params.svh"

package nocArbPkg;

  // One-hot grant states. Bit 0 is IDLE, bit p+1 grants port p.
  typedef enum logic [`NUM_PORTS:0] {
    IDLE    = 6'b000001,
    GRANT_L = 6'b000010,
    GRANT_N = 6'b000100,
    GRANT_E = 6'b001000,
    GRANT_W = 6'b010000,
    GRANT_S = 6'b100000
  } grantState;

  // First requesting port strictly after port from, wrapping around.
  // Port from itself is looked at last.
  function automatic grantState nextInRotation(
    input logic [`NUM_PORTS-1:0] req,
    input int unsigned from
  );
    grantState next;
    int unsigned idx;
    next = IDLE;
    // Walk from the farthest port back, so the nearest one wins.
    for (int i = `NUM_PORTS; i > 0; i--)
    begin
      idx = from + i;
      if (idx >= `NUM_PORTS)
        idx = idx - `NUM_PORTS;
      if (req[idx])
        next = grantState'({{`NUM_PORTS{1'b0}}, 1'b1} << (idx + 1));
    end
    return next;
  endfunction

endpackage

/* source/inputChannel.sv */
`timescale 1ns/1ps
`include "routerPort_params.svh"

module inputChannel (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inReq,
  input  nocFlitPkg::flitKind   inKind,
  input  logic [`LENGTH_W-1:0]  inLength,
  input  logic [`DATA_W-1:0]    inData,
  output logic                  inAck,
  input  logic                  pop,
  output logic                  pending,
  output nocFlitPkg::flitKind   heldKind,
  output logic [`LENGTH_W-1:0]  heldLength,
  output logic [`DATA_W-1:0]    heldData
);
  import nocFlitPkg::*;

  typedef enum logic [1:0] {
    EMPTY,
    FULL_ACKED,
    WAIT_REQ_LOW
  } chanState;

  chanState state;
  logic     capture;

  // Take a new flit only with the buffer free and the last handshake closed.
  assign capture = (state == EMPTY) && inReq && !inAck;
  assign pending = (state == FULL_ACKED);

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= EMPTY;
    else
    begin
      case (state)
        EMPTY:
          if (capture)
            state <= FULL_ACKED;
        FULL_ACKED:
          if (pop)
            state <= (inAck && inReq) ? WAIT_REQ_LOW : EMPTY;
        WAIT_REQ_LOW:
          if (!inReq)
            state <= EMPTY;
        default:
          state <= EMPTY;
      endcase
    end
  end

  // Receiver side of the four-phase handshake.
  always_ff @(posedge clk)
  begin
    if (rst)
      inAck <= 1'b0;
    else if (capture)
      inAck <= 1'b1;
    else if (!inReq)
      inAck <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      heldKind   <= inKind;
      heldLength <= inLength;
      heldData   <= inData;
    end
  end

endmodule

/* source/packetTimer.sv */
`timescale 1ns/1ps
`include "routerPort_params.svh"

module packetTimer (
  input  logic                  clk,
  input  logic                  rst,
  input  nocFlitPkg::flitKind   heldKind,
  input  logic [`LENGTH_W-1:0]  heldLength,
  input  logic                  run,
  output logic                  timesUp
);
  import nocFlitPkg::*;

  logic [`LENGTH_W-1:0] limit;
  logic [`LENGTH_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // Each header sets the hold limit for its packet.
      if (heldKind == HEADER)
        limit <= heldLength;
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == limit);

endmodule

/* source/outputArbiter.sv */
`timescale 1ns/1ps
`include "routerPort_params.svh"

module outputArbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] pending,
  input  nocFlitPkg::flitKind   heldKind [`NUM_PORTS],
  input  logic [`LENGTH_W-1:0]  heldLength [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0] grant
);
  import nocFlitPkg::*;
  import nocArbPkg::*;

  grantState             state;
  grantState             nextState;
  int unsigned           curPort;
  logic                  granted;
  logic [`NUM_PORTS-1:0] inPacket;
  logic [`NUM_PORTS-1:0] run;
  logic [`NUM_PORTS-1:0] timesUp;

  // --------------------------------------------------
  // Per-port hold timers
  // --------------------------------------------------
  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : genTimer
    packetTimer timer (
      .clk        (clk),
      .rst        (rst),
      .heldKind   (heldKind[p]),
      .heldLength (heldLength[p]),
      .run        (run[p]),
      .timesUp    (timesUp[p])
    );

    // A port still owns its packet until the tail has left the buffer.
    assign inPacket[p] = pending[p] || (heldKind[p] != TAIL);
  end

  // --------------------------------------------------
  // Grant state machine
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= nextState;
  end

  always_comb
  begin
    // IDLE rotates as if S held the grant last, so L comes first.
    curPort = `NUM_PORTS - 1;
    granted = 1'b0;
    case (state)
      GRANT_L:
      begin
        curPort = 0;
        granted = 1'b1;
      end
      GRANT_N:
      begin
        curPort = 1;
        granted = 1'b1;
      end
      GRANT_E:
      begin
        curPort = 2;
        granted = 1'b1;
      end
      GRANT_W:
      begin
        curPort = 3;
        granted = 1'b1;
      end
      GRANT_S:
      begin
        curPort = 4;
        granted = 1'b1;
      end
      default:
        granted = 1'b0;
    endcase
  end

  always_comb
  begin
    run = '0;
    if (granted && inPacket[curPort] && !timesUp[curPort])
    begin
      // Hold. Only a held grant advances the timer.
      run[curPort] = 1'b1;
      nextState    = state;
    end
    else
      nextState = nextInRotation(pending, curPort);
  end

  assign grant = state[`NUM_PORTS:1];

endmodule

/* source/outputChannel.sv */
`timescale 1ns/1ps
`include "routerPort_params.svh"

module outputChannel (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] grant,
  input  logic [`NUM_PORTS-1:0] pending,
  input  nocFlitPkg::flitKind   heldKind [`NUM_PORTS],
  input  logic [`LENGTH_W-1:0]  heldLength [`NUM_PORTS],
  input  logic [`DATA_W-1:0]    heldData [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0] pop,
  output logic                  outReq,
  output nocFlitPkg::flitKind   outKind,
  output logic [`LENGTH_W-1:0]  outLength,
  output logic [`DATA_W-1:0]    outData,
  output nocFlitPkg::portIdx    outSrc,
  input  logic                  outAck
);
  import nocFlitPkg::*;

  typedef enum logic [1:0] {
    SEND_IDLE,
    SEND_REQ,
    SEND_RELEASE
  } sendState;

  sendState              state;
  logic [`NUM_PORTS-1:0] ready;

  assign ready  = grant & pending;
  assign pop    = (state == SEND_IDLE) ? ready : '0;
  assign outReq = (state == SEND_REQ);

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= SEND_IDLE;
    else
    begin
      case (state)
        SEND_IDLE:
          if (|ready)
            state <= SEND_REQ;
        SEND_REQ:
          if (outAck)
            state <= SEND_RELEASE;
        SEND_RELEASE:
          if (!outAck)
            state <= SEND_IDLE;
        default:
          state <= SEND_IDLE;
      endcase
    end
  end

  // Latch the granted flit as it is popped.
  always_ff @(posedge clk)
  begin
    if (state == SEND_IDLE)
    begin
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        if (ready[p])
        begin
          outKind   <= heldKind[p];
          outLength <= heldLength[p];
          outData   <= heldData[p];
          outSrc    <= portIdx'(p);
        end
      end
    end
  end

endmodule

/* source/routerOutputPort.sv */
`timescale 1ns/1ps
`include "routerPort_params.svh"

module routerOutputPort (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] inReq,
  input  nocFlitPkg::flitKind   inKind [`NUM_PORTS],
  input  logic [`LENGTH_W-1:0]  inLength [`NUM_PORTS],
  input  logic [`DATA_W-1:0]    inData [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0] inAck,
  output logic                  outReq,
  output nocFlitPkg::flitKind   outKind,
  output logic [`LENGTH_W-1:0]  outLength,
  output logic [`DATA_W-1:0]    outData,
  output nocFlitPkg::portIdx    outSrc,
  input  logic                  outAck
);
  import nocFlitPkg::*;

  logic [`NUM_PORTS-1:0] pending;
  logic [`NUM_PORTS-1:0] pop;
  logic [`NUM_PORTS-1:0] grant;
  flitKind               heldKind [`NUM_PORTS];
  logic [`LENGTH_W-1:0]  heldLength [`NUM_PORTS];
  logic [`DATA_W-1:0]    heldData [`NUM_PORTS];

  // --------------------------------------------------
  // Input buffers, one per port in L, N, E, W, S order
  // --------------------------------------------------
  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : genInput
    inputChannel inChan (
      .clk        (clk),
      .rst        (rst),
      .inReq      (inReq[p]),
      .inKind     (inKind[p]),
      .inLength   (inLength[p]),
      .inData     (inData[p]),
      .inAck      (inAck[p]),
      .pop        (pop[p]),
      .pending    (pending[p]),
      .heldKind   (heldKind[p]),
      .heldLength (heldLength[p]),
      .heldData   (heldData[p])
    );
  end

  outputArbiter arbiter (
    .clk        (clk),
    .rst        (rst),
    .pending    (pending),
    .heldKind   (heldKind),
    .heldLength (heldLength),
    .grant      (grant)
  );

  outputChannel outChan (
    .clk        (clk),
    .rst        (rst),
    .grant      (grant),
    .pending    (pending),
    .heldKind   (heldKind),
    .heldLength (heldLength),
    .heldData   (heldData),
    .pop        (pop),
    .outReq     (outReq),
    .outKind    (outKind),
    .outLength  (outLength),
    .outData    (outData),
    .outSrc     (outSrc),
    .outAck     (outAck)
  );

endmodule

/* tests/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever
      #2 clk = ~clk;
  end

  // Reset held for the first 16 rising edges.
  initial
  begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* tests/routerOutputPort_props.sv */
`timescale 1ns/1ps
`include "routerPort_params.svh"

module routerOutputPortProps (
  input logic                  clk,
  input logic                  rst,
  input logic [`NUM_PORTS-1:0] inReq,
  input logic [`NUM_PORTS-1:0] inAck,
  input logic [`NUM_PORTS-1:0] grant,
  input logic                  outReq,
  input logic                  outAck,
  input logic [`FLIT_ID_W-1:0] outKind,
  input logic [`LENGTH_W-1:0]  outLength,
  input logic [`DATA_W-1:0]    outData,
  input logic [2:0]            outSrc
);

  int failCount = 0;

  // Output fields hold while the sink has not answered.
  assert property (@(posedge clk) disable iff (rst)
    (outReq && !outAck) |=> $stable({outKind, outLength, outData, outSrc}))
  else
  begin
    $error("output fields changed during a handshake");
    failCount++;
  end

  assert property (@(posedge clk) disable iff (rst) $rose(outReq) |-> !outAck)
  else
  begin
    $error("outReq rose while outAck was high");
    failCount++;
  end

  assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
  else
  begin
    $error("grant is not one-hot or zero");
    failCount++;
  end

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : genAck
    assert property (@(posedge clk) disable iff (rst) $fell(inAck[p]) |-> !$past(inReq[p]))
    else
    begin
      $error("inAck fell before inReq fell on port %0d", p);
      failCount++;
    end
  end

endmodule

bind routerOutputPort routerOutputPortProps props (
  .clk       (clk),
  .rst       (rst),
  .inReq     (inReq),
  .inAck     (inAck),
  .grant     (grant),
  .outReq    (outReq),
  .outAck    (outAck),
  .outKind   (outKind),
  .outLength (outLength),
  .outData   (outData),
  .outSrc    (outSrc)
);

/* tests/routerOutputPortTb.sv */
`timescale 1ns/1ps
`include "routerPort_params.svh"

module routerOutputPortTb;

  logic                  clk;
  logic                  rst;
  logic [`NUM_PORTS-1:0] inReq;
  nocFlitPkg::flitKind   inKind [`NUM_PORTS];
  logic [`LENGTH_W-1:0]  inLength [`NUM_PORTS];
  logic [`DATA_W-1:0]    inData [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] inAck;
  logic                  outReq;
  nocFlitPkg::flitKind   outKind;
  logic [`LENGTH_W-1:0]  outLength;
  logic [`DATA_W-1:0]    outData;
  nocFlitPkg::portIdx    outSrc;
  logic                  outAck;

  // Trace contents.
  int tTest[$];
  int tPort[$];
  int tKind[$];
  int tLen[$];
  int tData[$];
  int stallMin [16];
  int stallMax [16];
  int numTests = 0;

  // Flits driven but not yet seen on the output.
  int expPort[$];
  int expKind[$];
  int expLen[$];
  int expData[$];

  int errorCount = 0;
  int testErrors = 0;
  int curTest = 0;
  int cycles = 0;
  int cycleLimit = 1000000;
  int accepted [`NUM_PORTS];
  int sent [`NUM_PORTS];
  int snapUnsent [`NUM_PORTS];
  int lastSrc = -1;
  int openPacket = -1;
  int switchCount = 0;
  int stallCnt = 0;
  int stallTarget = 0;
  int postReset = 0;
  int resetEdges = 0;
  logic [`NUM_PORTS-1:0] prevAck;
  logic prevReq;

  clockGen clkGen (
    .clk (clk),
    .rst (rst)
  );

  routerOutputPort dut (
    .clk       (clk),
    .rst       (rst),
    .inReq     (inReq),
    .inKind    (inKind),
    .inLength  (inLength),
    .inData    (inData),
    .inAck     (inAck),
    .outReq    (outReq),
    .outKind   (outKind),
    .outLength (outLength),
    .outData   (outData),
    .outSrc    (outSrc),
    .outAck    (outAck)
  );

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Error: %s got %h expected %h", name, got, exp);
      errorCount++;
      testErrors++;
    end
  endtask

  task automatic reportProblem(input string msg);
    $display("%s", msg);
    errorCount++;
    testErrors++;
  endtask

  task automatic readTrace();
    int fd;
    int t;
    int p;
    int k;
    int l;
    int d;
    string line;
    string tag;
    fd = $fopen("tests/routerOutputPort_trace.txt", "r");
    if (fd == 0)
    begin
      reportProblem("Could not open the trace file tests/routerOutputPort_trace.txt");
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#")
        continue;
      void'($sscanf(line, "%s", tag));
      if (tag == "S")
      begin
        void'($sscanf(line, "%s %d %d %d", tag, t, k, l));
        stallMin[t] = k;
        stallMax[t] = l;
        if (t > numTests)
          numTests = t;
      end
      else if (tag == "F")
      begin
        void'($sscanf(line, "%s %d %d %h %h %h", tag, t, p, k, l, d));
        tTest.push_back(t);
        tPort.push_back(p);
        tKind.push_back(k);
        tLen.push_back(l);
        tData.push_back(d);
      end
    end
    $fclose(fd);
  endtask

  // Four-phase sender for one port, walking its flits of one test in order.
  task automatic sendPort(input int p, input int t);
    int gap;
    for (int i = 0; i < tTest.size(); i++)
    begin
      if (tTest[i] != t || tPort[i] != p)
        continue;
      gap = $urandom_range(3, 0);
      repeat (gap) @(posedge clk);
      expPort.push_back(p);
      expKind.push_back(tKind[i]);
      expLen.push_back(tLen[i]);
      expData.push_back(tData[i]);
      inReq[p]    <= 1'b1;
      inKind[p]   <= nocFlitPkg::flitKind'(tKind[i]);
      inLength[p] <= tLen[i];
      inData[p]   <= tData[i];
      do
        @(posedge clk);
      while (!inAck[p]);
      inReq[p] <= 1'b0;
      do
        @(posedge clk);
      while (inAck[p]);
    end
  endtask

  // One output flit seen. Checks order, fields, rotation and contiguity.
  task automatic handleOutput();
    int src;
    int idx;
    int k;
    src = int'(outSrc);
    idx = -1;
    if (src >= `NUM_PORTS)
    begin
      reportProblem($sformatf("Output carried an invalid source port %0d", src));
      return;
    end
    for (int i = 0; i < expPort.size(); i++)
    begin
      if (expPort[i] == src)
      begin
        idx = i;
        break;
      end
    end
    if (idx < 0)
    begin
      reportProblem($sformatf("Port %0d produced a flit that was never sent", src));
      return;
    end
    checkValue("outKind", outKind, expKind[idx]);
    checkValue("outLength", outLength, expLen[idx]);
    checkValue("outData", outData, expData[idx]);
    if (openPacket >= 0 && openPacket != src)
      reportProblem($sformatf("Port %0d broke into the open packet of port %0d", src, openPacket));
    if (lastSrc >= 0 && src != lastSrc)
    begin
      switchCount++;
      k = (lastSrc + 1) % `NUM_PORTS;
      while (k != src)
      begin
        if (snapUnsent[k] > 0)
          reportProblem($sformatf("Port %0d was passed over with a waiting flit", k));
        k = (k + 1) % `NUM_PORTS;
      end
    end
    if (expKind[idx] == 1 && expLen[idx] == 'hfff)
      openPacket = src;
    else if (expKind[idx] == 4 && openPacket == src)
      openPacket = -1;
    expPort.delete(idx);
    expKind.delete(idx);
    expLen.delete(idx);
    expData.delete(idx);
    sent[src]++;
    lastSrc = src;
    for (int j = 0; j < `NUM_PORTS; j++)
      snapUnsent[j] = accepted[j] - sent[j];
  endtask

  // --------------------------------------------------
  // Output monitor and sink
  // --------------------------------------------------
  always @(posedge clk)
  begin
    if (rst || postReset < 4)
    begin
      // The first edge only applies the synchronous reset.
      if (resetEdges > 0)
      begin
        checkValue("outReq", outReq, 0);
        checkValue("inAck", inAck, 0);
      end
      if (rst)
        resetEdges++;
      else
        postReset++;
    end
    else
    begin
      for (int p = 0; p < `NUM_PORTS; p++)
        if (inAck[p] && !prevAck[p])
          accepted[p]++;
      if (outReq && !prevReq)
        handleOutput();
    end
    prevAck = inAck;
    prevReq = outReq;
  end

  always @(posedge clk)
  begin
    if (rst)
      outAck <= 1'b0;
    else if (outReq && !outAck)
    begin
      if (stallCnt >= stallTarget)
      begin
        outAck   <= 1'b1;
        stallCnt = 0;
      end
      else
        stallCnt++;
    end
    else if (outAck && !outReq)
    begin
      outAck <= 1'b0;
      stallTarget = stallMin[curTest] +
                    $urandom_range(stallMax[curTest] - stallMin[curTest], 0);
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > cycleLimit)
    begin
      $display("Run stopped: cycle limit reached before all handshakes completed");
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic string testName(input int t);
    case (t)
      1: return "delivery and order";
      2: return "packet contiguity";
      3: return "rotation";
      4: return "timeout release";
      5: return "back-pressure";
      default: return "extra";
    endcase
  endfunction

  task automatic runTest(input int t);
    curTest = t;
    testErrors = 0;
    switchCount = 0;
    lastSrc = -1;
    fork
      sendPort(0, t);
      sendPort(1, t);
      sendPort(2, t);
      sendPort(3, t);
      sendPort(4, t);
    join
    while (expPort.size() != 0 || outReq || outAck)
      @(posedge clk);
    // Zero-length packets must interleave instead of going out whole.
    if (t == 4 && switchCount < 2)
      reportProblem("Zero-length packets were not interleaved between the two ports");
    $display("result for test %0d (%s): %s", t, testName(t), (testErrors == 0) ? "pass" : "fail");
  endtask

  initial
  begin
    int propFails;
    void'($urandom(32'h0e96_2e68));
    inReq  = '0;
    outAck = 1'b0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      inKind[p]   = nocFlitPkg::flitKind'(0);
      inLength[p] = '0;
      inData[p]   = '0;
      accepted[p] = 0;
      sent[p]     = 0;
      snapUnsent[p] = 0;
    end
    readTrace();
    cycleLimit = 64 * tTest.size() + 200;
    do
      @(posedge clk);
    while (rst || postReset < 4);
    $display("result for test 0 (reset state): %s", (errorCount == 0) ? "pass" : "fail");
    for (int t = 1; t <= numTests; t++)
      runTest(t);
    propFails = dut.props.failCount;
    $display("checks done: %0d tests, %0d errors, %0d assertion failures",
             numTests + 1, errorCount, propFails);
    if (errorCount == 0 && propFails == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* routerOutputPort.f */
+incdir+source
source/nocFlitPkg.sv
source/nocArbPkg.sv
source/inputChannel.sv
source/packetTimer.sv
source/outputArbiter.sv
source/outputChannel.sv
source/routerOutputPort.sv
tests/clockGen.sv
tests/routerOutputPort_props.sv
tests/routerOutputPortTb.sv

/* tests/routerOutputPort_trace.txt */
# S test minStall maxStall : sink stall range for the test, in cycles
# F test port kind length data : one flit, port 0..4 = L N E W S, kind 1 H 2 B 4 T, hex fields
S 1 0 3
F 1 0 1 fff 1001
F 1 0 4 000 1002
F 1 2 1 fff 1201
F 1 2 4 000 1202
F 1 4 1 fff 1401
F 1 4 4 000 1402
S 2 0 2
F 2 1 1 fff 2101
F 2 1 2 000 2102
F 2 1 4 000 2103
F 2 3 1 fff 2301
F 2 3 2 000 2302
F 2 3 4 000 2303
S 3 2 5
F 3 0 1 fff 3001
F 3 0 4 000 3002
F 3 1 1 fff 3101
F 3 1 4 000 3102
F 3 3 1 fff 3301
F 3 3 4 000 3302
F 3 4 1 fff 3401
F 3 4 4 000 3402
S 4 1 1
F 4 0 1 000 4001
F 4 0 2 000 4002
F 4 0 2 000 4003
F 4 0 2 000 4004
F 4 0 4 000 4005
F 4 2 1 000 4201
F 4 2 2 000 4202
F 4 2 2 000 4203
F 4 2 2 000 4204
F 4 2 4 000 4205
S 5 10 20
F 5 1 1 fff 5101
F 5 1 2 000 5102
F 5 1 4 000 5103
F 5 4 1 fff 5401
F 5 4 2 000 5402
F 5 4 4 000 5403
